//--- apb_pwm.f
+incdir+logic
logic/pwm_pkg.sv
logic/pwm_cfg_if.sv
logic/pwm_apb_regs.sv
logic/pwm_timebase.sv
logic/pwm_shadow_regs.sv
logic/pwm_channels.sv
logic/apb_pwm.sv
testbench/tb_clock_gen.sv
testbench/tb_apb_pwm.sv

//--- Makefile
# Verilator build and run for the APB PWM controller

VERILATOR ?= verilator
TOP       ?= tb_apb_pwm
FILELIST  ?= apb_pwm.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) logic/*.sv logic/*.svh testbench/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_apb_pwm.sv
/*
  APB PWM controller testbench
  Register access checks and per-channel pulse measurement against the
  duty and period rules, including channel disable and mid-period rewrites
*/
`timescale 1ns/10ps
`include "pwm_consts.svh"

module tb_apb_pwm;

  localparam int unsigned TEST_PERIODS = 20;
  localparam int unsigned MARGIN       = 2;

  logic       PCLK;
  logic       PRESETN;
  logic       psel;
  logic       penable;
  logic       pwrite;
  logic [7:0] paddr;
  logic [7:0] pwdata;
  logic [7:0] prdata;
  logic       pready;
  logic       pslverr;
  logic [3:0] pwm;

  int unsigned seed;
  int unsigned errors;
  int unsigned cyc;
  int unsigned wd_limit;
  int unsigned pulses;
  int unsigned period_clks;
  int unsigned prescale_v;
  int unsigned period_v;
  int unsigned exp_high [4];
  int unsigned alt_high [4];
  int unsigned last_rise [4];
  logic [7:0]  pos_e [4];
  logic [7:0]  neg_e [4];
  logic [3:0]  chk_mask;
  logic [3:0]  prev_pwm;
  logic [3:0]  rise_ok;
  logic [3:0]  last_ok;
  logic        armed;
  logic        per_chk;

  tb_clock_gen u_clk (
    .clk (PCLK)
  );

  apb_pwm u_apb_pwm (
    .PCLK    (PCLK),
    .PRESETN (PRESETN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .pwm     (pwm)
  );

  task automatic report_err(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  // Bus never stalls and never errors
  assert property (@(posedge PCLK) pready && !pslverr)
    else report_err("pready low or pslverr high");

  function automatic int unsigned duty_clks(input int unsigned pos, input int unsigned neg);
    return ((neg + period_v + 1 - pos) % (period_v + 1)) * (prescale_v + 1);
  endfunction

  function automatic logic [7:0] pos_addr(input int ch);
    return 8'(`PWM_POSEDGE_BASE + ch * `PWM_CH_STRIDE);
  endfunction

  function automatic logic [7:0] neg_addr(input int ch);
    return 8'(`PWM_NEGEDGE_BASE + ch * `PWM_CH_STRIDE);
  endfunction

  task automatic wait_clks(input int unsigned n);
    repeat (n) @(posedge PCLK);
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
    @(posedge PCLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge PCLK);
    penable <= 1'b1;
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic check_read(input logic [7:0] addr, input logic [7:0] exp);
    @(posedge PCLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge PCLK);
    penable <= 1'b1;
    @(negedge PCLK);
    assert (prdata == exp)
      else report_err($sformatf("read 0x%02h got 0x%02h, expected 0x%02h", addr, prdata, exp));
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // Random edges for every channel with pos below neg when nowrap is set
  task automatic pick_edges(input logic nowrap);
    int unsigned r;
    for (int ch = 0; ch < 4; ch++)
    begin
      r = $random(seed);
      if (nowrap)
      begin
        pos_e[ch] = 8'(r % period_v);
        neg_e[ch] = 8'(pos_e[ch] + 1 + (r >> 8) % (period_v - pos_e[ch]));
      end
      else
      begin
        pos_e[ch] = 8'(r % (period_v + 1));
        neg_e[ch] = 8'((pos_e[ch] + 1 + (r >> 8) % period_v) % (period_v + 1));
      end
    end
  endtask

  task automatic write_edges();
    for (int ch = 0; ch < 4; ch++)
    begin
      apb_write(pos_addr(ch), pos_e[ch]);
      apb_write(neg_addr(ch), neg_e[ch]);
    end
  endtask

  task automatic set_expect(input logic keep_old);
    for (int ch = 0; ch < 4; ch++)
    begin
      alt_high[ch] = keep_old ? exp_high[ch] : duty_clks(pos_e[ch], neg_e[ch]);
      exp_high[ch] = duty_clks(pos_e[ch], neg_e[ch]);
    end
  endtask

  always @(posedge PCLK)
  begin
    cyc <= cyc + 1;
  end

  // Watchdog
  always @(posedge PCLK)
  begin
    if (cyc > wd_limit)
    begin
      $display("Timeout: the test did not finish within %0d cycles", wd_limit);
      $display("Checks failed");
      $finish;
    end
  end

  // Pulse monitor for high time and rise-to-rise interval per channel
  always @(negedge PCLK)
  begin
    for (int ch = 0; ch < 4; ch++)
    begin
      if (!armed || !chk_mask[ch])
      begin
        rise_ok[ch] = 1'b0;
        last_ok[ch] = 1'b0;
      end
      else if (pwm[ch] && !prev_pwm[ch])
      begin
        if (last_ok[ch] && per_chk)
          assert (cyc - last_rise[ch] == period_clks)
            else report_err($sformatf("ch%0d interval %0d, expected %0d",
                                      ch, cyc - last_rise[ch], period_clks));
        last_rise[ch] = cyc;
        last_ok[ch]   = 1'b1;
        rise_ok[ch]   = 1'b1;
      end
      else if (!pwm[ch] && prev_pwm[ch] && rise_ok[ch])
      begin
        assert (cyc - last_rise[ch] == exp_high[ch] || cyc - last_rise[ch] == alt_high[ch])
          else report_err($sformatf("ch%0d high %0d, expected %0d", ch,
                                    cyc - last_rise[ch], exp_high[ch]));
        pulses++;
      end
    end
    prev_pwm = pwm;
  end

  initial
  begin
    int unsigned r;
    seed     = 32'h934b_0211;
    errors   = 0;
    cyc      = 0;
    wd_limit = 5000;
    pulses   = 0;
    armed    = 1'b0;
    per_chk  = 1'b1;
    chk_mask = 4'hf;
    prev_pwm = 4'h0;
    PRESETN  = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = 8'h00;
    pwdata   = 8'h00;
    wait_clks(8);
    PRESETN <= 1'b1;

    // Reset state
    @(negedge PCLK);
    assert (pwm == 4'h0) else report_err("pwm not zero after reset");
    check_read(`PWM_PRESCALE_ADDR, 8'h00);
    check_read(`PWM_PERIOD_ADDR, 8'h00);
    check_read(`PWM_ENABLE_ADDR, 8'h00);
    for (int ch = 0; ch < 4; ch++)
    begin
      check_read(pos_addr(ch), 8'h00);
      check_read(neg_addr(ch), 8'h00);
    end

    // Read-back of random values with a four-bit enable
    r = $random(seed);
    apb_write(`PWM_PRESCALE_ADDR, 8'(r));
    apb_write(`PWM_PERIOD_ADDR, 8'(r >> 8));
    apb_write(`PWM_ENABLE_ADDR, 8'(r >> 16));
    check_read(`PWM_PRESCALE_ADDR, 8'(r));
    check_read(`PWM_PERIOD_ADDR, 8'(r >> 8));
    check_read(`PWM_ENABLE_ADDR, {4'h0, 4'(r >> 16)});
    for (int ch = 0; ch < 4; ch++)
    begin
      r = $random(seed);
      apb_write(pos_addr(ch), 8'(r));
      apb_write(neg_addr(ch), 8'(r >> 8));
      check_read(pos_addr(ch), 8'(r));
      check_read(neg_addr(ch), 8'(r >> 8));
    end
    check_read(8'h01, 8'h00);
    check_read(8'h0c, 8'h00);
    check_read(8'h11, 8'h00);
    check_read(8'h30, 8'h00);
    check_read(8'hff, 8'h00);

    // Random timebase and duty on all channels
    r           = $random(seed);
    prescale_v  = 8 + r % 4;
    period_v    = 5 + (r >> 8) % 8;
    period_clks = (period_v + 1) * (prescale_v + 1);
    wd_limit    = cyc + TEST_PERIODS * period_clks * MARGIN + 2000;
    apb_write(`PWM_PRESCALE_ADDR, 8'(prescale_v));
    apb_write(`PWM_PERIOD_ADDR, 8'(period_v));
    pick_edges(1'b0);
    write_edges();
    set_expect(1'b0);
    apb_write(`PWM_ENABLE_ADDR, 8'h0f);
    wait_clks(2 * period_clks);
    armed = 1'b1;
    wait_clks(4 * period_clks);
    assert (pulses >= 8) else report_err("too few pulses seen with all channels on");

    // Channel 1 disabled
    armed    = 1'b0;
    chk_mask = 4'b1101;
    apb_write(`PWM_ENABLE_ADDR, 8'h0d);
    wait_clks(2 * period_clks);
    armed  = 1'b1;
    pulses = 0;
    repeat (2 * period_clks)
    begin
      @(negedge PCLK);
      assert (pwm[1] == 1'b0) else report_err("disabled channel 1 went high");
    end
    assert (pulses >= 3) else report_err("too few pulses seen with channel 1 disabled");

    // Non-wrapping edges, then a mid-period rewrite
    armed    = 1'b0;
    chk_mask = 4'hf;
    apb_write(`PWM_ENABLE_ADDR, 8'h0f);
    pick_edges(1'b1);
    write_edges();
    set_expect(1'b0);
    wait_clks(2 * period_clks);
    armed = 1'b1;
    wait_clks(period_clks);
    pick_edges(1'b1);
    set_expect(1'b1);
    per_chk = 1'b0;
    do
      @(negedge PCLK);
    while (!u_apb_pwm.sync_pulse);
    r = $random(seed);
    wait_clks(r % (period_clks - 26));
    write_edges();
    wait_clks(2 * period_clks);
    set_expect(1'b0);
    per_chk = 1'b1;
    pulses  = 0;
    wait_clks(3 * period_clks);
    assert (pulses >= 8) else report_err("too few pulses seen after edge rewrite");

    $display("Errors: %0d", errors);
    if (errors == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clock_gen.sv
/*
  Testbench clock source
  Free-running clock with a 4 ns period
*/
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

endmodule

//--- logic/apb_pwm.sv
/*
  APB PWM controller
  Four channel pulse-width modulator programmed over an 8-bit APB bus,
  with a shared prescaler and period counter
*/
`timescale 1ns/10ps

module apb_pwm (
  input  logic               PCLK,
  input  logic               PRESETN,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  pwm_pkg::apb_addr_t paddr,
  input  pwm_pkg::apb_data_t pwdata,
  output pwm_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  output pwm_pkg::pwm_vec_t  pwm
);
  import pwm_pkg::*;

  apb_data_t   period_cnt;
  logic        tick;
  logic        sync_pulse;
  pwm_vec_t    act_enable;
  edge_array_t act_posedge;
  edge_array_t act_negedge;

  pwm_cfg_if cfg_if ();

  pwm_apb_regs u_regs (
    .PCLK    (PCLK),
    .PRESETN (PRESETN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .cfg     (cfg_if.regs_mp)
  );

  pwm_timebase u_timebase (
    .PCLK       (PCLK),
    .PRESETN    (PRESETN),
    .cfg        (cfg_if.timebase_mp),
    .period_cnt (period_cnt),
    .tick       (tick),
    .sync_pulse (sync_pulse)
  );

  pwm_shadow_regs u_shadow (
    .PCLK        (PCLK),
    .PRESETN     (PRESETN),
    .cfg         (cfg_if.shadow_mp),
    .sync_pulse  (sync_pulse),
    .act_enable  (act_enable),
    .act_posedge (act_posedge),
    .act_negedge (act_negedge)
  );

  pwm_channels u_channels (
    .PCLK        (PCLK),
    .PRESETN     (PRESETN),
    .tick        (tick),
    .period_cnt  (period_cnt),
    .act_enable  (act_enable),
    .act_posedge (act_posedge),
    .act_negedge (act_negedge),
    .pwm         (pwm)
  );

  // No wait states and no error responses
  assign pready  = 1'b1;
  assign pslverr = 1'b0;

endmodule

//--- logic/pwm_channels.sv
/*
  PWM channel comparators
  Compares the period count with each channel's active edge positions on
  every tick and drives the registered PWM outputs
*/
`timescale 1ns/10ps
`include "pwm_consts.svh"

module pwm_channels (
  input  logic                 PCLK,
  input  logic                 PRESETN,
  input  logic                 tick,
  input  pwm_pkg::apb_data_t   period_cnt,
  input  pwm_pkg::pwm_vec_t    act_enable,
  input  pwm_pkg::edge_array_t act_posedge,
  input  pwm_pkg::edge_array_t act_negedge,
  output pwm_pkg::pwm_vec_t    pwm
);
  import pwm_pkg::*;

  pwm_vec_t hit_pos;
  pwm_vec_t hit_neg;

  always_comb
  begin
    for (int i = 0; i < `PWM_NUM; i++)
    begin
      hit_pos[i] = tick && (period_cnt == act_posedge[i]);
      hit_neg[i] = tick && (period_cnt == act_negedge[i]);
    end
  end

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      pwm <= '0;
    end
    else
    begin
      for (int i = 0; i < `PWM_NUM; i++)
      begin
        if (!act_enable[i])
        begin
          pwm[i] <= 1'b0;
        end
        // Falling edge has priority
        else if (hit_neg[i])
        begin
          pwm[i] <= 1'b0;
        end
        else if (hit_pos[i])
        begin
          pwm[i] <= 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/pwm_shadow_regs.sv
/*
  PWM shadow registers
  Active copies of the channel enable and edge settings, refreshed only
  at the end of a PWM period so a period is never split
*/
`timescale 1ns/10ps

module pwm_shadow_regs (
  input  logic                 PCLK,
  input  logic                 PRESETN,
  pwm_cfg_if.shadow_mp         cfg,
  input  logic                 sync_pulse,
  output pwm_pkg::pwm_vec_t    act_enable,
  output pwm_pkg::edge_array_t act_posedge,
  output pwm_pkg::edge_array_t act_negedge
);

  // Enable follows the same boundary as the edges
  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      act_enable <= '0;
    end
    else if (sync_pulse)
    begin
      act_enable <= cfg.enable;
    end
  end

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      act_posedge <= '0;
      act_negedge <= '0;
    end
    else if (sync_pulse)
    begin
      act_posedge <= cfg.pos_edge;
      act_negedge <= cfg.neg_edge;
    end
  end

endmodule

//--- logic/pwm_timebase.sv
/*
  PWM timebase
  Divides PCLK by prescale+1 into ticks and counts ticks modulo period+1,
  flagging the last tick of each PWM period
*/
`timescale 1ns/10ps

module pwm_timebase (
  input  logic               PCLK,
  input  logic               PRESETN,
  pwm_cfg_if.timebase_mp     cfg,
  output pwm_pkg::apb_data_t period_cnt,
  output logic               tick,
  output logic               sync_pulse
);
  import pwm_pkg::*;

  apb_data_t prescale_cnt;
  logic      prescale_wrap;
  logic      period_end;

  // Terminal counts, a lowered limit still wraps at once
  assign prescale_wrap = (prescale_cnt >= cfg.prescale);
  assign period_end    = (period_cnt >= cfg.period);

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      prescale_cnt <= '0;
      tick         <= 1'b0;
    end
    else if (prescale_wrap)
    begin
      prescale_cnt <= '0;
      tick         <= 1'b1;
    end
    else
    begin
      prescale_cnt <= prescale_cnt + 1'b1;
      tick         <= 1'b0;
    end
  end

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      period_cnt <= '0;
    end
    else if (tick)
    begin
      period_cnt <= period_end ? '0 : period_cnt + 1'b1;
    end
  end

  // Last tick of the period
  assign sync_pulse = tick & period_end;

endmodule

//--- logic/pwm_apb_regs.sv
/*
  PWM APB register block
  Zero wait state APB slave holding prescale, period, enable and edge
  registers, with a combinational read-back multiplexer
*/
`timescale 1ns/10ps
`include "pwm_consts.svh"

module pwm_apb_regs (
  input  logic               PCLK,
  input  logic               PRESETN,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  pwm_pkg::apb_addr_t paddr,
  input  pwm_pkg::apb_data_t pwdata,
  output pwm_pkg::apb_data_t prdata,
  pwm_cfg_if.regs_mp         cfg
);
  import pwm_pkg::*;

  apb_data_t   prescale_reg;
  apb_data_t   period_reg;
  pwm_vec_t    enable_reg;
  edge_array_t posedge_reg;
  edge_array_t negedge_reg;
  logic        wr_en;

  // Address of one channel's edge register
  function automatic apb_addr_t edge_addr(input apb_addr_t base, input int ch);
    return apb_addr_t'(base + ch * `PWM_CH_STRIDE);
  endfunction

  // Access phase of a write
  assign wr_en = psel & penable & pwrite;

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      prescale_reg <= '0;
      period_reg   <= '0;
      enable_reg   <= '0;
      posedge_reg  <= '0;
      negedge_reg  <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        `PWM_PRESCALE_ADDR: prescale_reg <= pwdata;
        `PWM_PERIOD_ADDR:   period_reg   <= pwdata;
        `PWM_ENABLE_ADDR:   enable_reg   <= pwdata[`PWM_NUM-1:0];
        default:
        begin
        end
      endcase
      for (int i = 0; i < `PWM_NUM; i++)
      begin
        if (paddr == edge_addr(`PWM_POSEDGE_BASE, i))
        begin
          posedge_reg[i] <= pwdata;
        end
        if (paddr == edge_addr(`PWM_NEGEDGE_BASE, i))
        begin
          negedge_reg[i] <= pwdata;
        end
      end
    end
  end

  // Read-back returns programmed values, unmapped offsets give zero
  always_comb
  begin
    prdata = '0;
    if (psel)
    begin
      case (paddr)
        `PWM_PRESCALE_ADDR: prdata = prescale_reg;
        `PWM_PERIOD_ADDR:   prdata = period_reg;
        `PWM_ENABLE_ADDR:   prdata = {{(`APB_DWIDTH-`PWM_NUM){1'b0}}, enable_reg};
        default:
        begin
        end
      endcase
      for (int i = 0; i < `PWM_NUM; i++)
      begin
        if (paddr == edge_addr(`PWM_POSEDGE_BASE, i))
        begin
          prdata = posedge_reg[i];
        end
        if (paddr == edge_addr(`PWM_NEGEDGE_BASE, i))
        begin
          prdata = negedge_reg[i];
        end
      end
    end
  end

  assign cfg.prescale = prescale_reg;
  assign cfg.period   = period_reg;
  assign cfg.enable   = enable_reg;
  assign cfg.pos_edge = posedge_reg;
  assign cfg.neg_edge = negedge_reg;

endmodule

//--- logic/pwm_cfg_if.sv
/*
  PWM configuration interface
  Carries the programmed timebase and channel settings out of the register block
*/
`timescale 1ns/10ps

interface pwm_cfg_if;
  import pwm_pkg::*;

  apb_data_t   prescale;
  apb_data_t   period;
  pwm_vec_t    enable;
  edge_array_t pos_edge;
  edge_array_t neg_edge;

  modport regs_mp (
    output prescale,
    output period,
    output enable,
    output pos_edge,
    output neg_edge
  );

  modport timebase_mp (
    input prescale,
    input period
  );

  modport shadow_mp (
    input enable,
    input pos_edge,
    input neg_edge
  );

endinterface

//--- logic/pwm_pkg.sv
/*
  PWM controller types
  APB word and address types, channel vector and per-channel edge array
*/
`include "pwm_consts.svh"

package pwm_pkg;

  // One APB data word
  typedef logic [`APB_DWIDTH-1:0] apb_data_t;

  // One APB address
  typedef logic [`APB_AWIDTH-1:0] apb_addr_t;

  // One bit per channel
  typedef logic [`PWM_NUM-1:0] pwm_vec_t;

  // One edge position per channel
  typedef apb_data_t [`PWM_NUM-1:0] edge_array_t;

endpackage

//--- logic/pwm_consts.svh
/*
  PWM controller constants
  Channel count, APB widths and register map offsets
*/
`ifndef PWM_CONSTS_SVH
`define PWM_CONSTS_SVH

// Channel count and APB widths
`define PWM_NUM     4
`define APB_DWIDTH  8
`define APB_AWIDTH  8

// Global registers
`define PWM_PRESCALE_ADDR  8'h00
`define PWM_PERIOD_ADDR    8'h04
`define PWM_ENABLE_ADDR    8'h08

// Channel n edges live at base + n * stride
`define PWM_POSEDGE_BASE   8'h10
`define PWM_NEGEDGE_BASE   8'h14
`define PWM_CH_STRIDE      8

`endif
